// ==== Makefile ====
TOP = tb_conv_soc

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -j 0 --top-module $(TOP) -f conv_soc.f

run: compile
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "^sim passed$$"

clean:
	rm -rf obj_dir

// ==== bench/conv_checker.sv ====
`timescale 1ns/1ps

module conv_checker (
    input  logic               clk,
    input  conv_pkg::mem_req_t bus_req_i,
    input  logic               exp_en_i,
    input  conv_pkg::word_t    exp_data_i,
    input  logic [127:0]       exp_name_i,
    input  conv_pkg::word_t    rdata_i,
    input  logic               rvalid_i,
    output int                 value_errs_o,
    output int                 resp_errs_o
);

    logic            pend = 1'b0;   // load strobed on the last rising edge
    logic            pend_en = 1'b0;
    conv_pkg::word_t pend_data = '0;
    logic [127:0]    pend_name = '0;
    int              value_errs = 0;
    int              resp_errs = 0;

    assign value_errs_o = value_errs;
    assign resp_errs_o  = resp_errs;

    // bus inputs change on the falling edge, so take them here
    always @(posedge clk) begin
        pend      <= bus_req_i.valid && bus_req_i.rd;
        pend_en   <= exp_en_i;
        pend_data <= exp_data_i;
        pend_name <= exp_name_i;
    end

    // dut outputs settle after the rising edge
    always @(negedge clk) begin
        if (pend && rvalid_i && pend_en && (rdata_i !== pend_data)) begin
            $display("Error %0s: expected %h, actual %h", pend_name, pend_data, rdata_i);
            value_errs++;
        end else if (rvalid_i && !pend) begin
            $display("read response arrived without a load request");
            resp_errs++;
        end else if (pend && !rvalid_i) begin
            $display("read response missing one cycle after the load");
            resp_errs++;
        end
    end

endmodule

// ==== bench/conv_trace.txt ====
# s addr data wbe, l addr expect name, p polls status until done (hex fields)
# m addr n w0.., f addr n base step, c addr n name e0.. (decimal values)
l 80000044 00000001 reset_status
l 40000000 00000000 unmapped
s 10000010 deadbeef f
s 10000014 12345678 f
l 10000010 deadbeef dmem_word0
l 10000014 12345678 dmem_word1
s 10000010 aabbccdd 5
s 10000014 55660000 c
l 10000010 debbbedd wbe_lanes02
l 10000014 55665678 wbe_lanes23
s 80000048 00000008 f
s 8000004c 00000100 f
s 80000050 00000200 f
s 80000054 00000300 f
l 80000048 00000008 cfg_fm_dim
l 8000004c 00000100 cfg_wt_off
l 80000050 00000200 cfg_ifm_off
l 80000054 00000300 cfg_ofm_off
m 10000400 9 1 -2 3 -4 5 -6 7 -8 9
f 10000800 64 -100 3
s 80000040 00000001 f
p
l 80000044 00000003 done_status
c 10000c00 6 ofm_row0 -215 -200 -185 -170 -155 -140
c 10000c18 6 ofm_row1 -95 -80 -65 -50 -35 -20
c 10000c30 6 ofm_row2 25 40 55 70 85 100
c 10000c48 6 ofm_row3 145 160 175 190 205 220
c 10000c60 6 ofm_row4 265 280 295 310 325 340
c 10000c78 6 ofm_row5 385 400 415 430 445 460
s 80000040 00000001 f
l 80000044 00000000 run_status
s 80000040 00000002 f
l 80000044 00000001 soft_rst_status

// ==== bench/tb_conv_soc.sv ====
`timescale 1ns/1ps
`include "conv_defs.svh"

module tb_conv_soc;

    localparam conv_pkg::addr_t STATUS_ADDR  = `CONV_REG_BASE + 32'(`CONV_REG_STATUS);
    localparam int              RESP_TIMEOUT = 8;       // cycles to wait for rvalid
    localparam int              POLL_TIMEOUT = 20000;   // status reads before giving up

    logic               clk = 1'b0;
    logic               rst_i;
    conv_pkg::mem_req_t bus_req;
    conv_pkg::word_t    rdata;
    logic               rvalid;
    logic               exp_en;
    conv_pkg::word_t    exp_data;
    logic [127:0]       exp_name;
    int                 value_errs;
    int                 resp_errs;
    int                 tb_errs;
    logic               abort;
    int                 fd;

    always #50 clk = ~clk;

    conv_soc_top i_dut (
        .clk       (clk),
        .rst_i     (rst_i),
        .bus_req_i (bus_req),
        .rdata_o   (rdata),
        .rvalid_o  (rvalid)
    );

    conv_checker i_chk (
        .clk          (clk),
        .bus_req_i    (bus_req),
        .exp_en_i     (exp_en),
        .exp_data_i   (exp_data),
        .exp_name_i   (exp_name),
        .rdata_i      (rdata),
        .rvalid_i     (rvalid),
        .value_errs_o (value_errs),
        .resp_errs_o  (resp_errs)
    );

    // entered and left on a falling edge
    task automatic bus_write(input conv_pkg::addr_t addr, input conv_pkg::word_t data,
                             input conv_pkg::wbe_t wbe);
        bus_req = '{addr: addr, wdata: data, wbe: wbe, rd: 1'b0, valid: 1'b1};
        @(negedge clk);
        bus_req.valid = 1'b0;
    endtask

    task automatic bus_read(input conv_pkg::addr_t addr, input logic check,
                            input conv_pkg::word_t exp_val, input logic [127:0] name,
                            output conv_pkg::word_t data);
        int n;
        bus_req  = '{addr: addr, wdata: '0, wbe: '0, rd: 1'b1, valid: 1'b1};
        exp_en   = check;       // checker latches these with the strobe
        exp_data = exp_val;
        exp_name = name;
        @(negedge clk);
        bus_req.valid = 1'b0;
        for (n = 0; n < RESP_TIMEOUT && !rvalid; n++) begin
            @(negedge clk);
        end
        data = rdata;
        if (!rvalid) begin
            $display("no read response from address %h", addr);
            tb_errs++;
            abort = 1'b1;
        end
    endtask

    task automatic poll_done;
        conv_pkg::word_t status;
        int              tries;
        status = '0;
        for (tries = 0; tries < POLL_TIMEOUT && !status[1] && !abort; tries++) begin
            bus_read(STATUS_ADDR, 1'b0, '0, '0, status);
        end
        if (!status[1] && !abort) begin
            $display("timeout waiting for the convolution done flag");
            tb_errs++;
            abort = 1'b1;
        end
    endtask

    task automatic check_fields(input int got, input int want);
        if (got != want) begin
            $display("malformed trace line, %0d of %0d fields read", got, want);
            tb_errs++;
            abort = 1'b1;
        end
    endtask

    task automatic run_trace;
        logic [7:0]      cmd;
        logic [959:0]    skip;
        logic [127:0]    name;
        conv_pkg::addr_t addr;
        conv_pkg::word_t data;
        conv_pkg::word_t got;
        conv_pkg::wbe_t  wbe;
        int              cnt;
        int              n;
        int              k;
        int              v;
        int              step;
        while (!abort && $fscanf(fd, "%s", cmd) == 1) begin
            case (cmd)
                "#": cnt = $fgets(skip, fd);    // column notes
                "s": begin
                    cnt = $fscanf(fd, "%h %h %h", addr, data, wbe);
                    check_fields(cnt, 3);
                    bus_write(addr, data, wbe);
                end
                "l": begin
                    cnt = $fscanf(fd, "%h %h %s", addr, data, name);
                    check_fields(cnt, 3);
                    bus_read(addr, 1'b1, data, name, got);
                end
                "m": begin
                    cnt = $fscanf(fd, "%h %d", addr, n);
                    check_fields(cnt, 2);
                    for (k = 0; k < n && !abort; k++) begin
                        cnt = $fscanf(fd, "%d", v);
                        check_fields(cnt, 1);
                        bus_write(addr + 4 * k, v, '1);
                    end
                end
                "f": begin
                    cnt = $fscanf(fd, "%h %d %d %d", addr, n, v, step);
                    check_fields(cnt, 4);
                    for (k = 0; k < n && !abort; k++) begin
                        bus_write(addr + 4 * k, v + k * step, '1);   // linear in address
                    end
                end
                "c": begin
                    cnt = $fscanf(fd, "%h %d %s", addr, n, name);
                    check_fields(cnt, 3);
                    for (k = 0; k < n && !abort; k++) begin
                        cnt = $fscanf(fd, "%d", v);
                        check_fields(cnt, 1);
                        bus_read(addr + 4 * k, 1'b1, v, name, got);
                    end
                end
                "p": poll_done;
                default: begin
                    $display("unknown trace command %s", cmd);
                    tb_errs++;
                    abort = 1'b1;
                end
            endcase
        end
    endtask

    initial begin
        rst_i    = 1'b1;
        bus_req  = '0;
        exp_en   = 1'b0;
        exp_data = '0;
        exp_name = '0;
        tb_errs  = 0;
        abort    = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_i = 1'b0;
        @(negedge clk);
        fd = $fopen("bench/conv_trace.txt", "r");
        if (fd == 0) begin
            $display("cannot open the trace file bench/conv_trace.txt");
            tb_errs++;
        end else begin
            run_trace;
            $fclose(fd);
        end
        repeat (2) @(negedge clk);
        $display("errors: %0d value, %0d response, %0d testbench",
                 value_errs, resp_errs, tb_errs);
        if (value_errs + resp_errs + tb_errs == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// ==== conv_soc.f ====
+incdir+rtl
rtl/conv_pkg.sv
rtl/dmem_wbe.sv
rtl/conv_ctrl_regs.sv
rtl/conv_engine.sv
rtl/conv_soc_top.sv
bench/conv_checker.sv
bench/tb_conv_soc.sv

// ==== rtl/conv_ctrl_regs.sv ====
`timescale 1ns/1ps
`include "conv_defs.svh"

module conv_ctrl_regs (
    input  logic                clk,
    input  logic                rst_i,
    input  conv_pkg::mem_req_t  bus_req_i,
    output conv_pkg::word_t     rdata_o,
    input  logic                idle_i,
    input  logic                finish_i,
    output logic                start_o,
    output logic                soft_rst_o,
    output conv_pkg::conv_cfg_t cfg_o
);

    localparam conv_pkg::addr_t REG_BASE = `CONV_REG_BASE;

    logic            reg_hit;
    logic            wr_en;
    logic [4:0]      offset;
    logic            done_q;
    logic            idle_now;
    logic            done_now;
    conv_pkg::widx_t wr_idx;
    conv_pkg::word_t rd_val;

    assign reg_hit = bus_req_i.valid && (bus_req_i.addr[31:5] == REG_BASE[31:5]);
    assign wr_en   = reg_hit && !bus_req_i.rd && (|bus_req_i.wbe);
    assign offset  = bus_req_i.addr[4:0];
    assign wr_idx  = bus_req_i.wdata[`CONV_DMEM_IDX_W-1:0];

    // a strobe still in flight already counts in the status word
    assign idle_now = (idle_i && !start_o) || soft_rst_o;
    assign done_now = done_q && !start_o && !soft_rst_o;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            start_o    <= 1'b0;
            soft_rst_o <= 1'b0;
            done_q     <= 1'b0;
            cfg_o      <= '0;
        end else begin
            start_o    <= wr_en && (offset == `CONV_REG_CTRL) && bus_req_i.wdata[0];
            soft_rst_o <= wr_en && (offset == `CONV_REG_CTRL) && bus_req_i.wdata[1];
            if (start_o || soft_rst_o) begin
                done_q <= 1'b0;
            end else if (finish_i) begin
                done_q <= 1'b1;           // sticky until next start
            end
            if (wr_en) begin
                case (offset)
                    `CONV_REG_FM_DIM:  cfg_o.fm_dim  <= wr_idx;
                    `CONV_REG_WT_OFF:  cfg_o.wt_off  <= wr_idx;
                    `CONV_REG_IFM_OFF: cfg_o.ifm_off <= wr_idx;
                    `CONV_REG_OFM_OFF: cfg_o.ofm_off <= wr_idx;
                    default: ;
                endcase
            end
        end
    end

    always_comb begin
        rd_val = '0;                      // ctrl reads as zero
        case (offset)
            `CONV_REG_STATUS:  rd_val[1:0] = {done_now, idle_now};
            `CONV_REG_FM_DIM:  rd_val[`CONV_DMEM_IDX_W-1:0] = cfg_o.fm_dim;
            `CONV_REG_WT_OFF:  rd_val[`CONV_DMEM_IDX_W-1:0] = cfg_o.wt_off;
            `CONV_REG_IFM_OFF: rd_val[`CONV_DMEM_IDX_W-1:0] = cfg_o.ifm_off;
            `CONV_REG_OFM_OFF: rd_val[`CONV_DMEM_IDX_W-1:0] = cfg_o.ofm_off;
            default: ;
        endcase
    end

    // zero for any load outside the block
    always_ff @(posedge clk) begin
        if (bus_req_i.valid && bus_req_i.rd) begin
            rdata_o <= reg_hit ? rd_val : '0;
        end
    end

endmodule

// ==== rtl/conv_defs.svh ====
`ifndef CONV_DEFS_SVH
`define CONV_DEFS_SVH

// bus and memory geometry
`define CONV_AWIDTH      32
`define CONV_DWIDTH      32
`define CONV_WBE_W       4
`define CONV_DMEM_DEPTH  16384
`define CONV_DMEM_IDX_W  14

`define CONV_WT_DIM      3          // kernel side

// address map
`define CONV_DMEM_BASE   32'h1000_0000
`define CONV_REG_BASE    32'h8000_0040

// register offsets inside the block
`define CONV_REG_CTRL    5'h00
`define CONV_REG_STATUS  5'h04
`define CONV_REG_FM_DIM  5'h08
`define CONV_REG_WT_OFF  5'h0C
`define CONV_REG_IFM_OFF 5'h10
`define CONV_REG_OFM_OFF 5'h14

`endif

// ==== rtl/conv_engine.sv ====
`timescale 1ns/1ps
`include "conv_defs.svh"

module conv_engine (
    input  logic                clk,
    input  logic                rst_i,
    input  logic                soft_rst_i,
    input  logic                start_i,
    input  conv_pkg::conv_cfg_t cfg_i,
    output logic                busy_o,
    output logic                idle_o,
    output logic                finish_o,
    output conv_pkg::dport_t    port_a_o,
    input  conv_pkg::word_t     rdata_a_i,
    output conv_pkg::dport_t    port_b_o
);

    localparam conv_pkg::widx_t WT   = `CONV_WT_DIM;
    localparam logic [1:0]      KMAX = 2'(`CONV_WT_DIM - 1);

    conv_pkg::engine_state_t state;

    conv_pkg::widx_t r;             // output row
    conv_pkg::widx_t c;             // output column
    logic [1:0]      ki;            // kernel row
    logic [1:0]      kj;            // kernel column
    logic            ph;            // 0 weight read, 1 input read
    conv_pkg::widx_t wt_ptr;
    conv_pkg::widx_t in_ptr;
    conv_pkg::widx_t win_base;      // top-left input of current window
    conv_pkg::widx_t out_ptr;
    conv_pkg::widx_t next_base;
    conv_pkg::widx_t row_skip;
    conv_pkg::word_t wt_q;
    conv_pkg::word_t acc;
    conv_pkg::word_t prod;
    logic            rd_vld_q;
    logic            rd_ph_q;
    logic            last_rd;
    logic            last_c;
    logic            last_out;

    assign last_c    = (c == cfg_i.fm_dim - WT);
    assign last_out  = last_c && (r == cfg_i.fm_dim - WT);
    assign last_rd   = ph && (kj == KMAX) && (ki == KMAX);
    assign next_base = last_c ? win_base + WT : win_base + 1'b1;
    assign row_skip  = cfg_i.fm_dim - (WT - 1'b1);
    assign prod      = $signed(wt_q) * $signed(rdata_a_i);   // low 32 bits kept

    assign busy_o   = (state != conv_pkg::IDLE);
    assign idle_o   = (state == conv_pkg::IDLE);
    assign finish_o = (state == conv_pkg::DONE);

    // port a only reads, weight and input alternate
    assign port_a_o.idx   = ph ? in_ptr : wt_ptr;
    assign port_a_o.wdata = '0;
    assign port_a_o.wbe   = '0;

    assign port_b_o.idx   = out_ptr;
    assign port_b_o.wdata = acc;
    assign port_b_o.wbe   = (state == conv_pkg::WRITE) ? '1 : '0;

    always_ff @(posedge clk) begin
        if (rst_i || soft_rst_i) begin
            state    <= conv_pkg::IDLE;
            rd_vld_q <= 1'b0;
        end else begin
            rd_vld_q <= (state == conv_pkg::FETCH);
            case (state)
                conv_pkg::IDLE:  if (start_i) state <= conv_pkg::FETCH;
                conv_pkg::FETCH: if (last_rd) state <= conv_pkg::ACC;
                conv_pkg::ACC:   state <= conv_pkg::WRITE;     // last product lands
                conv_pkg::WRITE: state <= last_out ? conv_pkg::DONE : conv_pkg::FETCH;
                default:         state <= conv_pkg::IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        rd_ph_q <= ph;
        if (rd_vld_q) begin
            if (!rd_ph_q) begin
                wt_q <= rdata_a_i;
            end else begin
                acc <= acc + prod;
            end
        end
        case (state)
            conv_pkg::IDLE: begin
                if (start_i) begin
                    r        <= '0;
                    c        <= '0;
                    ki       <= '0;
                    kj       <= '0;
                    ph       <= 1'b0;
                    acc      <= '0;
                    wt_ptr   <= cfg_i.wt_off;
                    in_ptr   <= cfg_i.ifm_off;
                    win_base <= cfg_i.ifm_off;
                    out_ptr  <= cfg_i.ofm_off;
                end
            end
            conv_pkg::FETCH: begin
                ph <= !ph;
                if (!ph) begin
                    wt_ptr <= wt_ptr + 1'b1;
                end else if (kj == KMAX) begin
                    kj     <= '0;
                    ki     <= ki + 1'b1;
                    in_ptr <= in_ptr + row_skip;   // down to next kernel row
                end else begin
                    kj     <= kj + 1'b1;
                    in_ptr <= in_ptr + 1'b1;
                end
            end
            conv_pkg::WRITE: begin
                ki       <= '0;
                kj       <= '0;
                ph       <= 1'b0;
                acc      <= '0;
                wt_ptr   <= cfg_i.wt_off;
                win_base <= next_base;
                in_ptr   <= next_base;
                out_ptr  <= out_ptr + 1'b1;
                if (last_c) begin
                    c <= '0;
                    r <= r + 1'b1;
                end else begin
                    c <= c + 1'b1;
                end
            end
            default: ;
        endcase
    end

endmodule

// ==== rtl/conv_pkg.sv ====
`include "conv_defs.svh"

package conv_pkg;

    typedef logic [`CONV_AWIDTH-1:0]     addr_t;
    typedef logic [`CONV_DWIDTH-1:0]     word_t;
    typedef logic [`CONV_WBE_W-1:0]      wbe_t;
    typedef logic [`CONV_DMEM_IDX_W-1:0] widx_t;   // word index into dmem

    typedef struct packed {
        addr_t addr;
        word_t wdata;
        wbe_t  wbe;
        logic  rd;       // load when set, store otherwise
        logic  valid;    // single-cycle strobe
    } mem_req_t;

    typedef struct packed {
        widx_t idx;
        word_t wdata;
        wbe_t  wbe;
    } dport_t;

    typedef struct packed {
        widx_t fm_dim;
        widx_t wt_off;
        widx_t ifm_off;
        widx_t ofm_off;
    } conv_cfg_t;

    typedef enum logic [2:0] {IDLE, FETCH, ACC, WRITE, DONE} engine_state_t;

endpackage

// ==== rtl/conv_soc_top.sv ====
`timescale 1ns/1ps
`include "conv_defs.svh"

module conv_soc_top (
    input  logic               clk,
    input  logic               rst_i,
    input  conv_pkg::mem_req_t bus_req_i,
    output conv_pkg::word_t    rdata_o,
    output logic               rvalid_o
);

    localparam conv_pkg::addr_t DMEM_BASE = `CONV_DMEM_BASE;

    conv_pkg::dport_t    cpu_port;
    conv_pkg::dport_t    eng_port_a;
    conv_pkg::dport_t    port_a;
    conv_pkg::dport_t    eng_port_b;
    conv_pkg::word_t     dmem_rdata;
    conv_pkg::word_t     reg_rdata;
    conv_pkg::conv_cfg_t cfg;
    logic                dmem_sel;
    logic                busy;
    logic                idle;
    logic                finish;
    logic                start;
    logic                soft_rst;
    logic                dmem_rd_q;   // last load hit dmem

    // dmem region: addr[31:30] == 0 and addr[28] == 1
    assign dmem_sel = bus_req_i.valid
                   && (bus_req_i.addr[31:30] == DMEM_BASE[31:30])
                   && (bus_req_i.addr[28] == DMEM_BASE[28]);

    assign cpu_port.idx   = bus_req_i.addr[`CONV_DMEM_IDX_W+1:2];
    assign cpu_port.wdata = bus_req_i.wdata;
    assign cpu_port.wbe   = (dmem_sel && !bus_req_i.rd) ? bus_req_i.wbe : '0;

    assign port_a = busy ? eng_port_a : cpu_port;   // engine owns port a while busy

    always_ff @(posedge clk) begin
        if (rst_i) begin
            rvalid_o  <= 1'b0;
            dmem_rd_q <= 1'b0;
        end else begin
            rvalid_o  <= bus_req_i.valid && bus_req_i.rd;
            dmem_rd_q <= dmem_sel && bus_req_i.rd && !busy;
        end
    end

    // reg block returns zero for unmapped and blocked loads
    assign rdata_o = dmem_rd_q ? dmem_rdata : reg_rdata;

    dmem_wbe i_dmem (
        .clk       (clk),
        .port_a_i  (port_a),
        .rdata_a_o (dmem_rdata),
        .port_b_i  (eng_port_b)
    );

    conv_ctrl_regs i_regs (
        .clk        (clk),
        .rst_i      (rst_i),
        .bus_req_i  (bus_req_i),
        .rdata_o    (reg_rdata),
        .idle_i     (idle),
        .finish_i   (finish),
        .start_o    (start),
        .soft_rst_o (soft_rst),
        .cfg_o      (cfg)
    );

    conv_engine i_engine (
        .clk        (clk),
        .rst_i      (rst_i),
        .soft_rst_i (soft_rst),
        .start_i    (start),
        .cfg_i      (cfg),
        .busy_o     (busy),
        .idle_o     (idle),
        .finish_o   (finish),
        .port_a_o   (eng_port_a),
        .rdata_a_i  (dmem_rdata),
        .port_b_o   (eng_port_b)
    );

endmodule

// ==== rtl/dmem_wbe.sv ====
`timescale 1ns/1ps
`include "conv_defs.svh"

module dmem_wbe (
    input  logic             clk,
    input  conv_pkg::dport_t port_a_i,
    output conv_pkg::word_t  rdata_a_o,
    input  conv_pkg::dport_t port_b_i
);

    conv_pkg::word_t mem [`CONV_DMEM_DEPTH];

    // byte lanes written independently on both ports
    always_ff @(posedge clk) begin
        for (int i = 0; i < `CONV_WBE_W; i++) begin
            if (port_a_i.wbe[i]) begin
                mem[port_a_i.idx][i*8 +: 8] <= port_a_i.wdata[i*8 +: 8];
            end
            if (port_b_i.wbe[i]) begin
                mem[port_b_i.idx][i*8 +: 8] <= port_b_i.wdata[i*8 +: 8];
            end
        end
    end

    // port a read, one cycle latency
    always_ff @(posedge clk) begin
        rdata_a_o <= mem[port_a_i.idx];   // old data on same-cycle write
    end

endmodule
